// File: verilog/autotest_pkg.sv
// autotest package with the card block layout, vector types, controller states and SD host structs
package autotest_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] block_addr_t;
  typedef logic [9:0]  byte_count_t;
  typedef logic [31:0] signature_t;
  typedef logic [31:0] operand_t;
  typedef logic [31:0] result_t;
  typedef logic [31:0] exec_time_t;
  typedef logic [31:0] err_count_t;
  typedef logic [1:0]  debug_sel_t;

  localparam block_addr_t START_BLOCK = 32'h0010_0000;
  localparam int BLOCK_BYTES = 512;

  // field sizes in bytes
  localparam int SIG_BYTES = 4;
  localparam int IN1_BYTES = 4;
  localparam int IN2_BYTES = 4;
  localparam int OUT_BYTES = 4;

  // field offsets inside a block
  localparam int IN1_BASE = SIG_BYTES;
  localparam int IN2_BASE = IN1_BASE + IN1_BYTES;
  localparam int EXP_BASE = IN2_BASE + IN2_BYTES;

  localparam signature_t SIGNATURE = 32'hAABB_CCDD;
  localparam exec_time_t TIMEOUT_CYCLES = 32'd200;

  typedef enum logic [3:0] {
    INIT, SD_RESET, SD_RESET_WAIT, IDLE, BLOCK_REQ, BLOCK_WAIT, BYTE_REQ,
    BYTE_WAIT, CHECK_SIG, RUN, END_TEST, COMPARE, NEXT_BLOCK, HALT
  } ctrl_state_e;

  typedef struct packed {
    logic sd_rst;
    logic r_block;
    logic r_byte;
  } sd_req_t;

  typedef struct packed {
    logic  busy;
    byte_t data_out;
  } sd_rsp_t;

  typedef struct packed {
    signature_t signature;
    operand_t   in1;
    operand_t   in2;
    result_t    expected;
  } vector_t;

endpackage

// File: verilog/autotest_ctrl.sv
// autotest controller FSM sequencing SD reset, block reads, UUT runs, compare and block stepping
`timescale 1ns/1ps

module autotest_ctrl import autotest_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        sd_busy_i,
  output sd_req_t     sd_req_o,
  output logic        uut_rst_o,
  input  logic        uut_end_i,
  input  logic        uut_err_i,
  output logic        vec_clear_o,
  output logic        byte_valid_o,
  output byte_count_t byte_pos_o,
  input  logic        sig_ok_i,
  output logic        timer_clear_o,
  output logic        timer_run_o,
  input  logic        timeout_i,
  output logic        capture_o,
  output logic        compare_o,
  output logic        errs_clear_o,
  output logic        blk_init_o,
  output logic        blk_step_o,
  output ctrl_state_e state_o
);

  ctrl_state_e state;
  ctrl_state_e next_state;
  byte_count_t byte_pos;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= INIT;
    end else begin
      state <= next_state;
    end
  end

  // position of the next byte delivered by the host
  always_ff @(posedge clk) begin
    if (rst || state == IDLE) begin
      byte_pos <= '0;
    end else if (byte_valid_o) begin
      byte_pos <= byte_pos + 1'b1;
    end
  end

  always_comb begin
    next_state    = state;
    sd_req_o      = '0;
    uut_rst_o     = 1'b1;
    vec_clear_o   = 1'b0;
    byte_valid_o  = 1'b0;
    timer_clear_o = 1'b0;
    timer_run_o   = 1'b0;
    capture_o     = 1'b0;
    compare_o     = 1'b0;
    errs_clear_o  = 1'b0;
    blk_init_o    = 1'b0;
    blk_step_o    = 1'b0;
    case (state)
      INIT: begin
        errs_clear_o = 1'b1;
        blk_init_o   = 1'b1;
        next_state   = SD_RESET;
      end
      SD_RESET: begin
        sd_req_o.sd_rst = 1'b1;
        if (sd_busy_i) next_state = SD_RESET_WAIT;
      end
      SD_RESET_WAIT: begin
        if (!sd_busy_i) next_state = IDLE;
      end
      IDLE: begin
        vec_clear_o   = 1'b1;
        timer_clear_o = 1'b1;
        if (!sd_busy_i) next_state = BLOCK_REQ;
      end
      BLOCK_REQ: begin
        sd_req_o.r_block = 1'b1;
        if (sd_busy_i) next_state = BLOCK_WAIT;
      end
      BLOCK_WAIT: begin
        sd_req_o.r_block = 1'b1;
        if (!sd_busy_i) next_state = BYTE_REQ;
      end
      BYTE_REQ: begin
        sd_req_o.r_block = 1'b1;
        sd_req_o.r_byte  = 1'b1;
        if (sd_busy_i) next_state = BYTE_WAIT;
      end
      BYTE_WAIT: begin
        sd_req_o.r_block = 1'b1;
        if (!sd_busy_i) begin
          // data_out is valid this cycle
          byte_valid_o = 1'b1;
          if (byte_pos == byte_count_t'(BLOCK_BYTES - 1)) begin
            next_state = CHECK_SIG;
          end else begin
            next_state = BYTE_REQ;
          end
        end
      end
      CHECK_SIG: begin
        next_state = sig_ok_i ? RUN : HALT;
      end
      RUN: begin
        uut_rst_o   = 1'b0;
        timer_run_o = 1'b1;
        if (uut_end_i || uut_err_i || timeout_i) next_state = END_TEST;
      end
      END_TEST: begin
        uut_rst_o  = 1'b0;
        capture_o  = 1'b1;
        next_state = COMPARE;
      end
      COMPARE: begin
        uut_rst_o  = 1'b0;
        compare_o  = 1'b1;
        next_state = NEXT_BLOCK;
      end
      NEXT_BLOCK: begin
        blk_step_o = 1'b1;
        next_state = IDLE;
      end
      HALT: begin
        // parked here until reset after a bad signature
        uut_rst_o = 1'b0;
      end
      default: begin
        next_state = INIT;
      end
    endcase
  end

  assign byte_pos_o = byte_pos;
  assign state_o    = state;

  // a byte request only makes sense inside an open block read
  assert property (@(posedge clk) disable iff (rst)
    sd_req_o.r_byte |-> sd_req_o.r_block);

endmodule

// File: verilog/vector_store.sv
// vector store that places card bytes into signature, operands and expected result
`timescale 1ns/1ps

module vector_store import autotest_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        clear_i,
  input  logic        byte_valid_i,
  input  byte_count_t byte_pos_i,
  input  byte_t       byte_i,
  output vector_t     vec_o,
  output logic        sig_ok_o
);

  vector_t vec_q;
  logic    in_sig;
  logic    in_in1;
  logic    in_in2;
  logic    in_exp;

  // field decode of the byte position
  assign in_sig = byte_pos_i < IN1_BASE;
  assign in_in1 = (byte_pos_i >= IN1_BASE) && (byte_pos_i < IN2_BASE);
  assign in_in2 = (byte_pos_i >= IN2_BASE) && (byte_pos_i < EXP_BASE);
  assign in_exp = (byte_pos_i >= EXP_BASE) && (byte_pos_i < EXP_BASE + OUT_BYTES);

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      vec_q <= '0;
    end else if (byte_valid_i) begin
      if (in_sig) begin
        // signature arrives msb first
        vec_q.signature[8 * (SIG_BYTES - 1 - byte_pos_i) +: 8] <= byte_i;
      end else if (in_in1) begin
        vec_q.in1[8 * (byte_pos_i - IN1_BASE) +: 8] <= byte_i;
      end else if (in_in2) begin
        vec_q.in2[8 * (byte_pos_i - IN2_BASE) +: 8] <= byte_i;
      end else if (in_exp) begin
        vec_q.expected[8 * (byte_pos_i - EXP_BASE) +: 8] <= byte_i;
      end
      // rest of the block is padding
    end
  end

  assign vec_o    = vec_q;
  assign sig_ok_o = (vec_q.signature == SIGNATURE);

  assert property (@(posedge clk) disable iff (rst)
    byte_valid_i |-> (byte_pos_i < BLOCK_BYTES));

endmodule

// File: verilog/exec_timer.sv
// UUT execution timer that counts run cycles and flags the timeout
`timescale 1ns/1ps

module exec_timer import autotest_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       clear_i,
  input  logic       run_i,
  output exec_time_t exec_time_o,
  output logic       timeout_o
);

  exec_time_t count;
  logic       at_limit;

  assign at_limit = (count >= TIMEOUT_CYCLES);

  // saturates at the timeout value
  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      count <= '0;
    end else if (run_i && !at_limit) begin
      count <= count + 1'b1;
    end
  end

  assign exec_time_o = count;
  assign timeout_o   = at_limit;

endmodule

// File: verilog/result_checker.sv
// result checker that latches the UUT result and counts mismatches against the expected value
`timescale 1ns/1ps

module result_checker import autotest_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       capture_i,
  input  logic       compare_i,
  input  logic       errs_clear_i,
  input  result_t    uut_result_i,
  input  logic       uut_err_i,
  input  result_t    expected_i,
  output result_t    last_result_o,
  output err_count_t err_count_o
);

  result_t    result_q;
  logic       err_q;
  err_count_t err_count;
  logic       mismatch;

  always_ff @(posedge clk) begin
    if (capture_i) begin
      result_q <= uut_result_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      err_q <= 1'b0;
    end else if (capture_i) begin
      err_q <= uut_err_i;
    end
  end

  // an error flag counts as a failure even with a matching result
  assign mismatch = (result_q != expected_i) || err_q;

  always_ff @(posedge clk) begin
    if (rst || errs_clear_i) begin
      err_count <= '0;
    end else if (compare_i && mismatch) begin
      err_count <= err_count + 1'b1;
    end
  end

  assign last_result_o = result_q;
  assign err_count_o   = err_count;

  assert property (@(posedge clk) disable iff (rst) !(capture_i && compare_i));

endmodule

// File: verilog/block_tracker.sv
// block tracker with the vector block address counter and the debug word select
`timescale 1ns/1ps

module block_tracker import autotest_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        init_i,
  input  logic        step_i,
  output block_addr_t block_addr_o,
  input  debug_sel_t  debug_sel_i,
  input  ctrl_state_e state_i,
  input  exec_time_t  exec_time_i,
  input  err_count_t  err_count_i,
  input  result_t     last_result_i,
  output logic [31:0] debug_o
);

  block_addr_t block_addr;

  always_ff @(posedge clk) begin
    if (rst || init_i) begin
      block_addr <= START_BLOCK;
    end else if (step_i) begin
      block_addr <= block_addr + 1'b1;
    end
  end

  always_comb begin
    case (debug_sel_i)
      2'd0:    debug_o = {block_addr[15:0], 12'h000, state_i};
      2'd1:    debug_o = exec_time_i;
      2'd2:    debug_o = err_count_i;
      default: debug_o = last_result_i;
    endcase
  end

  assign block_addr_o = block_addr;

endmodule

// File: verilog/autotest_top.sv
// autotest top level wiring the controller to its datapath for the SD driven self-test
`timescale 1ns/1ps

module autotest_top import autotest_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  output sd_req_t     sd_req_o,
  input  sd_rsp_t     sd_rsp_i,
  output block_addr_t spi_block_addr_o,
  output logic        uut_rst_o,
  input  logic        uut_end_i,
  input  logic        uut_err_i,
  output operand_t    uut_in1_o,
  output operand_t    uut_in2_o,
  input  result_t     uut_result_i,
  input  debug_sel_t  debug_sel_i,
  output logic [31:0] debug_o
);

  logic        vec_clear;
  logic        byte_valid;
  byte_count_t byte_pos;
  logic        sig_ok;
  logic        timer_clear;
  logic        timer_run;
  logic        timeout;
  logic        capture;
  logic        compare;
  logic        errs_clear;
  logic        blk_init;
  logic        blk_step;
  ctrl_state_e state;
  vector_t     vec;
  exec_time_t  exec_time;
  result_t     last_result;
  err_count_t  err_count;

  autotest_ctrl u_ctrl (
    .clk(clk), .rst(rst), .sd_busy_i(sd_rsp_i.busy), .sd_req_o(sd_req_o),
    .uut_rst_o(uut_rst_o), .uut_end_i(uut_end_i), .uut_err_i(uut_err_i),
    .vec_clear_o(vec_clear), .byte_valid_o(byte_valid), .byte_pos_o(byte_pos),
    .sig_ok_i(sig_ok), .timer_clear_o(timer_clear), .timer_run_o(timer_run),
    .timeout_i(timeout), .capture_o(capture), .compare_o(compare),
    .errs_clear_o(errs_clear), .blk_init_o(blk_init), .blk_step_o(blk_step),
    .state_o(state)
  );

  vector_store u_vector_store (
    .clk(clk), .rst(rst), .clear_i(vec_clear), .byte_valid_i(byte_valid),
    .byte_pos_i(byte_pos), .byte_i(sd_rsp_i.data_out), .vec_o(vec), .sig_ok_o(sig_ok)
  );

  exec_timer u_exec_timer (
    .clk(clk), .rst(rst), .clear_i(timer_clear), .run_i(timer_run),
    .exec_time_o(exec_time), .timeout_o(timeout)
  );

  result_checker u_result_checker (
    .clk(clk), .rst(rst), .capture_i(capture), .compare_i(compare),
    .errs_clear_i(errs_clear), .uut_result_i(uut_result_i), .uut_err_i(uut_err_i),
    .expected_i(vec.expected), .last_result_o(last_result), .err_count_o(err_count)
  );

  block_tracker u_block_tracker (
    .clk(clk), .rst(rst), .init_i(blk_init), .step_i(blk_step),
    .block_addr_o(spi_block_addr_o), .debug_sel_i(debug_sel_i), .state_i(state),
    .exec_time_i(exec_time), .err_count_i(err_count), .last_result_i(last_result),
    .debug_o(debug_o)
  );

  assign uut_in1_o = vec.in1;
  assign uut_in2_o = vec.in2;

endmodule

// File: verif/sd_card_model.sv
// behavioral SD host with block memory, busy timing per request and byte delivery
`timescale 1ns/1ps

module sd_card_model import autotest_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  sd_req_t     sd_req_i,
  input  block_addr_t block_addr_i,
  output sd_rsp_t     sd_rsp_o
);

  localparam int NUM_BLOCKS = 8;
  localparam int RESET_BUSY = 5;
  localparam int START_BUSY = 3;
  localparam int BYTE_BUSY  = 2;

  byte_t       mem [NUM_BLOCKS * BLOCK_BYTES];
  logic        block_open;
  block_addr_t cur_addr;
  int          byte_idx;

  function automatic byte_t read_byte(input block_addr_t addr, input int pos);
    block_addr_t offset;
    offset = addr - START_BLOCK;
    if (offset < NUM_BLOCKS) begin
      return mem[int'(offset) * BLOCK_BYTES + pos];
    end
    return 8'hFF;
  endfunction

  task automatic load_vector(input block_addr_t addr, input signature_t sig,
                             input operand_t in1, input operand_t in2,
                             input result_t expected);
    int base;
    base = int'(addr - START_BLOCK) * BLOCK_BYTES;
    for (int i = 0; i < 4; i++) begin
      mem[base + i]            = sig[8 * (SIG_BYTES - 1 - i) +: 8];
      mem[base + IN1_BASE + i] = in1[8 * i +: 8];
      mem[base + IN2_BASE + i] = in2[8 * i +: 8];
      mem[base + EXP_BASE + i] = expected[8 * i +: 8];
    end
  endtask

  // a byte read leaves its data on the bus as busy falls
  task automatic hold_busy(input int cycles, input logic give_byte);
    sd_rsp_o.busy = 1'b1;
    repeat (cycles) @(posedge clk);
    #1;
    if (give_byte) begin
      sd_rsp_o.data_out = read_byte(cur_addr, byte_idx);
      byte_idx++;
    end
    sd_rsp_o.busy = 1'b0;
  endtask

  initial begin
    for (int i = 0; i < NUM_BLOCKS * BLOCK_BYTES; i++) begin
      mem[i] = byte_t'(i ^ (i >> 8));
    end
    sd_rsp_o   = '0;
    block_open = 1'b0;
    cur_addr   = '0;
    byte_idx   = 0;
    forever begin
      @(posedge clk);
      #1;
      if (rst) begin
        block_open    = 1'b0;
        sd_rsp_o.busy = 1'b0;
      end else if (sd_req_i.sd_rst) begin
        hold_busy(RESET_BUSY, 1'b0);
      end else if (sd_req_i.r_block && !block_open) begin
        block_open = 1'b1;
        cur_addr   = block_addr_i;
        byte_idx   = 0;
        hold_busy(START_BUSY, 1'b0);
      end else if (sd_req_i.r_byte && block_open) begin
        hold_busy(BYTE_BUSY, 1'b1);
      end
      if (!sd_req_i.r_block) begin
        block_open = 1'b0;
      end
    end
  end

endmodule

// File: verif/autotest_tb.sv
// testbench for the autotest sequencer with an SD card model and a UUT model
`timescale 1ns/1ps

module autotest_tb import autotest_pkg::*; ();

  localparam int BLOCK_CYCLES = BLOCK_BYTES * 8 + 64;
  localparam int RUN_CYCLES   = TIMEOUT_CYCLES + 16;
  localparam int NUM_TESTS    = 5;
  localparam longint WATCHDOG_NS = 40 * (NUM_TESTS * (BLOCK_CYCLES + RUN_CYCLES) + 400);

  logic        clk = 1'b0;
  logic        rst;
  sd_req_t     sd_req;
  sd_rsp_t     sd_rsp;
  block_addr_t block_addr;
  logic        uut_rst;
  logic        uut_end;
  logic        uut_err;
  operand_t    uut_in1;
  operand_t    uut_in2;
  result_t     uut_result;
  debug_sel_t  debug_sel;
  logic [31:0] debug_word;

  // UUT model controls
  int          uut_delay;
  logic        uut_err_mode;
  logic        uut_hang;
  logic        uut_active;

  logic [15:0] lfsr_state;
  operand_t    op_a [4];
  operand_t    op_b [4];

  always #20 clk = ~clk;

  autotest_top dut (
    .clk(clk), .rst(rst), .sd_req_o(sd_req), .sd_rsp_i(sd_rsp),
    .spi_block_addr_o(block_addr), .uut_rst_o(uut_rst), .uut_end_i(uut_end),
    .uut_err_i(uut_err), .uut_in1_o(uut_in1), .uut_in2_o(uut_in2),
    .uut_result_i(uut_result), .debug_sel_i(debug_sel), .debug_o(debug_word)
  );

  sd_card_model sd (
    .clk(clk), .rst(rst), .sd_req_i(sd_req), .block_addr_i(block_addr), .sd_rsp_o(sd_rsp)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped after a failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else abort_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic random_operand(output operand_t value);
    value = '0;
    for (int i = 0; i < 32; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic read_debug(input debug_sel_t sel, output logic [31:0] word);
    debug_sel = sel;
    #1;
    word = debug_word;
  endtask

  task automatic wait_uut_rst(input logic level, input int max_cycles, output int cycles);
    cycles = 0;
    while (uut_rst !== level) begin
      if (cycles >= max_cycles) begin
        abort_run($sformatf("uut_rst_o did not go to %0b within %0d cycles", level,
                            max_cycles));
      end
      @(posedge clk);
      #1;
      cycles++;
    end
  endtask

  // UUT model returns in1 + in2 some cycles after release or hangs
  initial begin
    uut_end    = 1'b0;
    uut_err    = 1'b0;
    uut_result = '0;
    uut_active = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (uut_rst) begin
        uut_active = 1'b0;
        uut_end    = 1'b0;
        uut_err    = 1'b0;
      end else if (!uut_active) begin
        uut_active = 1'b1;
        uut_result = '0;
        if (!uut_hang) begin
          repeat (uut_delay) @(posedge clk);
          #1;
          uut_result = uut_in1 + uut_in2;
          uut_end    = 1'b1;
          uut_err    = uut_err_mode;
          @(posedge clk);
          #1;
          uut_end = 1'b0;
        end
      end
    end
  end

  task automatic load_vectors();
    for (int i = 0; i < 4; i++) begin
      random_operand(op_a[i]);
      random_operand(op_b[i]);
    end
    sd.load_vector(START_BLOCK, SIGNATURE, op_a[0], op_b[0], op_a[0] + op_b[0]);
    sd.load_vector(START_BLOCK + 1, SIGNATURE, op_a[1], op_b[1], op_a[1] + op_b[1] + 1);
    sd.load_vector(START_BLOCK + 2, SIGNATURE, op_a[2], op_b[2], op_a[2] + op_b[2]);
    sd.load_vector(START_BLOCK + 3, SIGNATURE, op_a[3], op_b[3], op_a[3] + op_b[3]);
    sd.load_vector(START_BLOCK + 4, SIGNATURE ^ 32'h1, op_a[0], op_b[0], op_a[0]);
  endtask

  task automatic test_reset();
    logic [31:0] word;
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    check_value("r_block after reset", sd_req.r_block, 1'b0);
    check_value("r_byte after reset", sd_req.r_byte, 1'b0);
    check_value("sd_rst after INIT", sd_req.sd_rst, 1'b1);
    check_value("uut_rst_o after reset", uut_rst, 1'b1);
    read_debug(2'd0, word);
    check_value("debug address field", word[31:16], START_BLOCK[15:0]);
    check_value("debug state field", word[3:0], SD_RESET);
  endtask

  // one block read, run and compare, checked at the next IDLE
  task automatic run_vector(input int idx, input int delay, input logic err_mode,
                            input logic hang, input err_count_t exp_errs);
    int          cycles;
    logic [31:0] word;
    uut_delay    = delay;
    uut_err_mode = err_mode;
    uut_hang     = hang;
    wait_uut_rst(1'b0, BLOCK_CYCLES, cycles);
    check_value("uut_in1_o", uut_in1, op_a[idx]);
    check_value("uut_in2_o", uut_in2, op_b[idx]);
    wait_uut_rst(1'b1, RUN_CYCLES, cycles);
    if (hang) begin
      assert (cycles >= TIMEOUT_CYCLES)
        else abort_run("hung UUT run ended before the timeout");
    end
    @(posedge clk);
    #1;
    check_value("block address", block_addr, block_addr_t'(START_BLOCK + idx + 1));
    read_debug(2'd2, word);
    check_value("error count", word, exp_errs);
    read_debug(2'd3, word);
    check_value("last result", word, hang ? 32'h0 : op_a[idx] + op_b[idx]);
    if (hang) begin
      read_debug(2'd1, word);
      check_value("execution time", word, TIMEOUT_CYCLES);
    end
  endtask

  task automatic test_passing_vector();
    run_vector(0, 6, 1'b0, 1'b0, 0);
  endtask

  task automatic test_failing_vector();
    run_vector(1, 3, 1'b0, 1'b0, 1);
  endtask

  task automatic test_error_flag();
    run_vector(2, 9, 1'b1, 1'b0, 2);
  endtask

  task automatic test_hang_timeout();
    run_vector(3, 0, 1'b0, 1'b1, 3);
  endtask

  task automatic test_bad_signature();
    int          cycles;
    logic [31:0] word;
    wait_uut_rst(1'b0, BLOCK_CYCLES, cycles);
    for (int i = 0; i < 64; i++) begin
      read_debug(2'd0, word);
      check_value("state after bad signature", word[3:0], HALT);
      check_value("uut_rst_o in halt", uut_rst, 1'b0);
      check_value("r_block in halt", sd_req.r_block, 1'b0);
      check_value("block address in halt", block_addr, block_addr_t'(START_BLOCK + 4));
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("watchdog expired at %0t ns before the tests finished", $time));
  end

  initial begin
    rst          = 1'b1;
    debug_sel    = 2'd0;
    uut_delay    = 4;
    uut_err_mode = 1'b0;
    uut_hang     = 1'b1;
    lfsr_state   = 16'd89;
    #1;
    load_vectors();
    test_reset();
    test_passing_vector();
    test_failing_vector();
    test_error_flag();
    test_hang_timeout();
    test_bad_signature();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: sources.f
verilog/autotest_pkg.sv
verilog/autotest_ctrl.sv
verilog/vector_store.sv
verilog/exec_timer.sv
verilog/result_checker.sv
verilog/block_tracker.sv
verilog/autotest_top.sv
verif/sd_card_model.sv
verif/autotest_tb.sv
